/* compile.f */
hdl/rtc_pkg.sv
hdl/i2c_byte_master.sv
hdl/rtc_ctrl.sv
hdl/rtc_top.sv
verif/pcf8563_model.sv
verif/tb_rtc_top.sv

/* hdl/i2c_byte_master.sv */
`timescale 1ns/1ps
//******************************
// single-register I2C write/read, sda_oe = 1 pulls SDA low
// no clock stretching, no arbitration, ACK bits ignored
// req must stay stable from exec until done
//******************************
module i2c_byte_master
    import rtc_pkg::*;
#(
    parameter int unsigned CLK_DIV  = 125,
    parameter logic [6:0]  DEV_ADDR = 7'h51
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       exec,
    input  i2c_req_t   req,
    input  logic       sda_in,
    output logic       done,
    output logic [7:0] data_r,
    output logic       scl,
    output logic       sda_oe
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_MAX = DIV_W'(CLK_DIV - 1);

    i2c_state_e       state;
    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    // quarter of the current bit time
    logic [1:0]       qtr;
    logic             phase_end;
    logic [2:0]       bit_cnt;
    // 0 addr+W, 1 reg, 2 data or addr+R, 3 read byte
    logic [1:0]       byte_idx;
    logic             ack_last;
    logic [7:0]       shreg;
    logic             rx_bit;
    logic             scl_d;
    logic             sda_oe_d;

    // byte to send in a given slot
    function automatic logic [7:0] tx_byte(input logic [1:0] idx, input i2c_req_t r);
        logic [7:0] b;
        case (idx)
            2'd0:    b = {DEV_ADDR, 1'b0};
            2'd1:    b = r.reg_addr;
            2'd2:    b = r.rh_wl ? {DEV_ADDR, 1'b1} : r.data_w;
            // all ones keeps SDA released while the chip drives
            default: b = 8'hff;
        endcase
        return b;
    endfunction

    //******************************
    // quarter-period tick
    //******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (state == I2C_IDLE || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign tick      = (state != I2C_IDLE) && (div_cnt == DIV_MAX);
    assign phase_end = tick && (qtr == 2'd3);

    // last ACK slot of the transaction, stop follows
    assign ack_last = (byte_idx == 2'd3) || (!req.rh_wl && byte_idx == 2'd2);

    //******************************
    // phase machine
    //******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= I2C_IDLE;
            qtr      <= 2'd0;
            bit_cnt  <= 3'd0;
            byte_idx <= 2'd0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state == I2C_IDLE) begin
                qtr      <= 2'd0;
                bit_cnt  <= 3'd0;
                byte_idx <= 2'd0;
                if (exec) begin
                    state <= I2C_START;
                end
            end else if (tick) begin
                qtr <= qtr + 2'd1;
                if (qtr == 2'd3) begin
                    case (state)
                        I2C_START: begin
                            state <= I2C_SHIFT;
                        end
                        I2C_SHIFT: begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7) begin
                                state <= I2C_ACK;
                            end
                        end
                        I2C_ACK: begin
                            byte_idx <= byte_idx + 2'd1;
                            if (ack_last) begin
                                state <= I2C_STOP;
                            end else if (req.rh_wl && byte_idx == 2'd1) begin
                                // switch direction after the register address
                                state <= I2C_RESTART;
                            end else begin
                                state <= I2C_SHIFT;
                            end
                        end
                        I2C_RESTART: begin
                            state <= I2C_SHIFT;
                        end
                        I2C_STOP: begin
                            state <= I2C_IDLE;
                            done  <= 1'b1;
                        end
                        default: begin
                            state <= I2C_IDLE;
                        end
                    endcase
                end
            end
        end
    end

    //******************************
    // shift register and read data
    //******************************
    always_ff @(posedge clk) begin
        if (state == I2C_IDLE && exec) begin
            shreg <= tx_byte(2'd0, req);
        end else if (phase_end && state == I2C_SHIFT) begin
            // shift at end of bit so SDA only moves with SCL low
            shreg <= {shreg[6:0], rx_bit};
        end else if (phase_end && state == I2C_ACK && !ack_last) begin
            shreg <= tx_byte(byte_idx + 2'd1, req);
        end
        // sample late in the high phase
        if (tick && qtr == 2'd2 && state == I2C_SHIFT) begin
            rx_bit <= sda_in;
        end
        // on a write this is the data byte read back off the bus
        if (phase_end && state == I2C_STOP) begin
            data_r <= shreg;
        end
    end

    //******************************
    // bus levels per phase and quarter
    //******************************
    always_comb begin
        scl_d    = 1'b1;
        sda_oe_d = 1'b0;
        case (state)
            I2C_START: begin
                // SDA falls in q1 with SCL high
                scl_d    = (qtr != 2'd3);
                sda_oe_d = (qtr != 2'd0);
            end
            I2C_SHIFT: begin
                scl_d    = ^qtr;
                sda_oe_d = ~shreg[7];
            end
            I2C_ACK: begin
                // released, also the NACK after the read byte
                scl_d    = ^qtr;
                sda_oe_d = 1'b0;
            end
            I2C_RESTART: begin
                scl_d    = ^qtr;
                sda_oe_d = qtr[1];
            end
            I2C_STOP: begin
                // SDA rises in q2 with SCL high
                scl_d    = (qtr != 2'd0);
                sda_oe_d = ~qtr[1];
            end
            default: begin
                scl_d    = 1'b1;
                sda_oe_d = 1'b0;
            end
        endcase
    end

    // registered pins, bus idle out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl    <= 1'b1;
            sda_oe <= 1'b0;
        end else begin
            scl    <= scl_d;
            sda_oe <= sda_oe_d;
        end
    end

    // SDA moves under high SCL only for start, restart or stop
    a_sda_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (scl && $past(scl) && (sda_oe != $past(sda_oe)))
        |-> ($past(state) == I2C_START || $past(state) == I2C_RESTART ||
             $past(state) == I2C_STOP));

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done);

endmodule

/* hdl/rtc_ctrl.sv */
`timescale 1ns/1ps
//******************************
// writes TIME_INIT once after the power-up wait, then reads forever
// ACK is never checked, a silent chip just reads back bus idle
// WAIT_CYCLES must be at least 1
//******************************
module rtc_ctrl
    import rtc_pkg::*;
#(
    parameter rtc_time_t   TIME_INIT   = 48'h19_01_01_09_30_00,
    parameter int unsigned WAIT_CYCLES = 8000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       done,
    input  logic [7:0] data_r,
    output logic       exec,
    output i2c_req_t   req,
    output rtc_time_t  time_now
);

    localparam int WAIT_W = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;
    localparam logic [WAIT_W-1:0] WAIT_MAX = WAIT_W'(WAIT_CYCLES - 1);

    ctrl_state_e       state;
    logic [WAIT_W-1:0] wait_cnt;
    // field index, 0 = sec .. 5 = year
    logic [2:0]        fld;
    logic [2:0]        fld_nxt;
    logic              fld_last;
    logic              rd_nxt;
    // a request is on the bus
    logic              pending_q;

    // start-time byte for a field
    function automatic logic [7:0] init_byte(input logic [2:0] idx);
        logic [7:0] b;
        case (idx)
            3'd0:    b = TIME_INIT.sec;
            3'd1:    b = TIME_INIT.min;
            3'd2:    b = TIME_INIT.hour;
            3'd3:    b = TIME_INIT.day;
            3'd4:    b = TIME_INIT.mon;
            default: b = TIME_INIT.year;
        endcase
        return b;
    endfunction

    //******************************
    // field walk
    //******************************
    assign fld_last = (fld == 3'd5);
    assign fld_nxt  = fld_last ? 3'd0 : fld + 3'd1;
    // once year is done the write pass is over for good
    assign rd_nxt   = req.rh_wl | fld_last;

    // exec lasts exactly the one ISSUE cycle
    assign exec = (state == CTRL_ISSUE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= CTRL_WAIT;
            wait_cnt <= '0;
            fld      <= 3'd0;
            req      <= '0;
            time_now <= '0;
        end else begin
            case (state)
                // power-up settle time of the chip
                CTRL_WAIT: begin
                    if (wait_cnt == WAIT_MAX) begin
                        state <= CTRL_ISSUE;
                        req   <= '{rh_wl: 1'b0, reg_addr: rtc_reg_addr(3'd0),
                                   data_w: init_byte(3'd0)};
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                CTRL_ISSUE: begin
                    state <= CTRL_BUSY;
                end
                CTRL_BUSY: begin
                    if (done) begin
                        state <= CTRL_ISSUE;
                        fld   <= fld_nxt;
                        req   <= '{rh_wl: rd_nxt, reg_addr: rtc_reg_addr(fld_nxt),
                                   data_w: init_byte(fld_nxt)};
                        // load even after writes, the value is stale until a read pass
                        case (fld)
                            3'd0:    time_now.sec  <= data_r & MASK_SEC;
                            3'd1:    time_now.min  <= data_r & MASK_MIN;
                            3'd2:    time_now.hour <= data_r & MASK_HOUR;
                            3'd3:    time_now.day  <= data_r & MASK_DAY;
                            3'd4:    time_now.mon  <= data_r & MASK_MON;
                            default: time_now.year <= data_r & MASK_YEAR;
                        endcase
                    end
                end
                default: begin
                    state <= CTRL_WAIT;
                end
            endcase
        end
    end

    //******************************
    // outstanding transaction
    //******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else if (exec) begin
            pending_q <= 1'b1;
        end else if (done) begin
            pending_q <= 1'b0;
        end
    end

    // no new request before the master answers
    a_exec_idle: assert property (@(posedge clk) disable iff (!rst_n)
        exec |-> !pending_q);

    // master only answers what was asked
    a_done_owed: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> pending_q);

endmodule

/* hdl/rtc_pkg.sv */
//******************************
// shared types for the rtc front end
// time fields are BCD bytes, sec in the low byte
// only the six calendar registers are covered
//******************************
package rtc_pkg;

    // calendar time, year in the top byte
    typedef struct packed {
        logic [7:0] year;
        logic [7:0] mon;
        logic [7:0] day;
        logic [7:0] hour;
        logic [7:0] min;
        logic [7:0] sec;
    } rtc_time_t;

    // one register access on the bus
    typedef struct packed {
        logic       rh_wl;     // 1 read, 0 write
        logic [7:0] reg_addr;
        logic [7:0] data_w;
    } i2c_req_t;

    typedef enum logic [1:0] {
        CTRL_WAIT,
        CTRL_ISSUE,
        CTRL_BUSY
    } ctrl_state_e;

    typedef enum logic [2:0] {
        I2C_IDLE,
        I2C_START,
        I2C_SHIFT,
        I2C_ACK,
        I2C_RESTART,
        I2C_STOP
    } i2c_state_e;

    // chip register map, weekday at 06h is skipped
    localparam logic [7:0] REG_SEC  = 8'h02;
    localparam logic [7:0] REG_MIN  = 8'h03;
    localparam logic [7:0] REG_HOUR = 8'h04;
    localparam logic [7:0] REG_DAY  = 8'h05;
    localparam logic [7:0] REG_MON  = 8'h07;
    localparam logic [7:0] REG_YEAR = 8'h08;

    // valid BCD bits per field
    localparam logic [7:0] MASK_SEC  = 8'h7f;
    localparam logic [7:0] MASK_MIN  = 8'h7f;
    localparam logic [7:0] MASK_HOUR = 8'h3f;
    localparam logic [7:0] MASK_DAY  = 8'h3f;
    localparam logic [7:0] MASK_MON  = 8'h1f;
    localparam logic [7:0] MASK_YEAR = 8'hff;

    // field index 0..5 to register address
    function automatic logic [7:0] rtc_reg_addr(input logic [2:0] idx);
        logic [7:0] a;
        case (idx)
            3'd0:    a = REG_SEC;
            3'd1:    a = REG_MIN;
            3'd2:    a = REG_HOUR;
            3'd3:    a = REG_DAY;
            3'd4:    a = REG_MON;
            default: a = REG_YEAR;
        endcase
        return a;
    endfunction

endpackage

/* hdl/rtc_top.sv */
`timescale 1ns/1ps
//******************************
// rtc front end, controller plus I2C master
// sda_in is the resolved bus level, pull-up is external
//******************************
module rtc_top
    import rtc_pkg::*;
#(
    // start time, year down to sec
    parameter rtc_time_t   TIME_INIT   = 48'h19_01_01_09_30_00,
    // power-up wait in clocks
    parameter int unsigned WAIT_CYCLES = 8000,
    // clocks per quarter SCL period
    parameter int unsigned CLK_DIV     = 125,
    parameter logic [6:0]  DEV_ADDR    = 7'h51
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      sda_in,
    output logic      scl,
    output logic      sda_oe,
    output rtc_time_t time_now
);

    // request path
    logic       exec;
    i2c_req_t   req;
    // answer path
    logic       done;
    logic [7:0] data_r;

    //******************************
    // register sequencer
    //******************************
    rtc_ctrl #(
        .TIME_INIT   (TIME_INIT),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) rtc_ctrl_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .done     (done),
        .data_r   (data_r),
        .exec     (exec),
        .req      (req),
        .time_now (time_now)
    );

    //******************************
    // bus engine
    //******************************
    i2c_byte_master #(
        .CLK_DIV  (CLK_DIV),
        .DEV_ADDR (DEV_ADDR)
    ) i2c_byte_master_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .exec   (exec),
        .req    (req),
        .sda_in (sda_in),
        .done   (done),
        .data_r (data_r),
        .scl    (scl),
        .sda_oe (sda_oe)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the rtc testbench with Verilator, run it, pass only on the pass line
verilator --binary --timing --assert -f compile.f --top-module tb_rtc_top -o tb_rtc_top \
    || exit 1
out=$(./obj_dir/tb_rtc_top 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Simulation finished: PASS' && exit 0 || exit 1

/* verif/pcf8563_model.sv */
`timescale 1ns/1ps
//******************************
// PCF8563-style bus slave, samples SCL/SDA on clk
// clk must run well above SCL, register pointer wraps at 16
//******************************
module pcf8563_model
    import rtc_pkg::*;
#(
    parameter logic [6:0] DEV_ADDR = 7'h51
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             scl,
    input  logic             sda,
    // 1 pulls SDA low
    output logic             sda_pull,
    // testbench hooks
    input  logic             load_en,
    input  logic [3:0]       load_addr,
    input  logic [7:0]       load_data,
    output int               pass_cnt,
    output int               wr_cnt,
    output logic [7:0][15:0] wr_log,
    output logic             bus_err
);

    logic [7:0] regs [0:15];
    logic       scl_q;
    logic       sda_q;
    // SCL rises seen in the current 9-bit frame
    logic [3:0] bitc;
    // bytes since the last START
    logic [2:0] byte_n;
    logic [7:0] rx_sh;
    logic [7:0] tx_sh;
    logic [7:0] ptr;
    logic       busy;
    logic       addressed;
    logic       rd_req;
    logic       tx_mode;
    // register address written in this transfer
    logic       ptr_ok;
    logic       rise;
    logic       fall;
    logic       start_c;
    logic       stop_c;
    logic       addr_hit;

    assign rise     = !scl_q && scl;
    assign fall     = scl_q && !scl;
    // SDA edge with SCL high in both samples
    assign start_c  = scl_q && scl && sda_q && !sda;
    assign stop_c   = scl_q && scl && !sda_q && sda;
    assign addr_hit = (rx_sh[7:1] == DEV_ADDR);

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            sda_pull  <= 1'b0;
            bitc      <= 4'd0;
            byte_n    <= 3'd0;
            rx_sh     <= 8'h00;
            tx_sh     <= 8'h00;
            ptr       <= 8'h00;
            busy      <= 1'b0;
            addressed <= 1'b0;
            rd_req    <= 1'b0;
            tx_mode   <= 1'b0;
            ptr_ok    <= 1'b0;
            pass_cnt  <= 0;
            wr_cnt    <= 0;
            wr_log    <= '0;
            bus_err   <= 1'b0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (load_en) begin
                regs[load_addr] <= load_data;
            end
            if (start_c) begin
                // restart only right after a frame boundary
                if (busy && bitc != 4'd1) begin
                    bus_err <= 1'b1;
                    $display("model: START in the middle of a byte at %0t", $time);
                end
                busy     <= 1'b1;
                bitc     <= 4'd0;
                byte_n   <= 3'd0;
                tx_mode  <= 1'b0;
                sda_pull <= 1'b0;
            end else if (stop_c) begin
                if (!busy || bitc != 4'd1) begin
                    bus_err <= 1'b1;
                    $display("model: STOP on an idle bus or inside a byte at %0t", $time);
                end
                busy     <= 1'b0;
                tx_mode  <= 1'b0;
                ptr_ok   <= 1'b0;
                sda_pull <= 1'b0;
            end else if (busy && rise) begin
                if (!tx_mode && bitc < 4'd8) begin
                    rx_sh <= {rx_sh[6:0], sda};
                end
                bitc <= bitc + 4'd1;
            end else if (busy && fall) begin
                if (bitc == 4'd8) begin
                    // byte complete, ACK slot follows
                    byte_n <= byte_n + 3'd1;
                    if (tx_mode) begin
                        sda_pull <= 1'b0;
                    end else if (byte_n == 3'd0) begin
                        addressed <= addr_hit;
                        rd_req    <= rx_sh[0];
                        sda_pull  <= addr_hit;
                        if (addr_hit && rx_sh[0] && !ptr_ok) begin
                            bus_err <= 1'b1;
                            $display("model: read with no register address at %0t", $time);
                        end
                    end else if (addressed) begin
                        sda_pull <= 1'b1;
                        if (byte_n == 3'd1) begin
                            ptr    <= rx_sh;
                            ptr_ok <= 1'b1;
                        end else begin
                            regs[ptr[3:0]] <= rx_sh;
                            ptr            <= ptr + 8'd1;
                            wr_cnt         <= wr_cnt + 1;
                            if (wr_cnt < 8) begin
                                wr_log[wr_cnt[2:0]] <= {ptr, rx_sh};
                            end
                        end
                    end
                end else if (bitc == 4'd9) begin
                    bitc <= 4'd0;
                    if (!tx_mode && addressed && rd_req && byte_n == 3'd1) begin
                        // address with R acked, put out the first data bit
                        tx_mode  <= 1'b1;
                        sda_pull <= ~regs[ptr[3:0]][7];
                        tx_sh    <= {regs[ptr[3:0]][6:0], 1'b0};
                        ptr      <= ptr + 8'd1;
                        if (ptr == REG_YEAR) begin
                            pass_cnt <= pass_cnt + 1;
                        end
                    end else begin
                        tx_mode  <= 1'b0;
                        sda_pull <= 1'b0;
                    end
                end else if (tx_mode) begin
                    sda_pull <= ~tx_sh[7];
                    tx_sh    <= {tx_sh[6:0], 1'b0};
                end
            end
        end
    end

endmodule

/* verif/tb_rtc_top.sv */
`timescale 1ns/1ps
//******************************
// rtc_top against the bus model with a 10 ns clock
// rows are loaded through the model hooks
// each row is checked after two read passes
//******************************
module tb_rtc_top
    import rtc_pkg::*;
();

    localparam rtc_time_t   TIME_INIT   = 48'h19_01_01_09_30_00;
    localparam int unsigned WAIT_CYCLES = 20;
    localparam int unsigned CLK_DIV     = 2;
    localparam logic [6:0]  DEV_ADDR    = 7'h51;
    localparam int          NUM_ROWS    = 4;
    // rows plus two passes of 6 transfers at up to 60 bit times each with 2x margin
    localparam int unsigned TIMEOUT_CYCLES = 2 * (NUM_ROWS + 2) * 6 * 60 * 4 * CLK_DIV;

    // raw chip bytes year down to sec with the undefined high bits set
    localparam rtc_time_t ROWS [NUM_ROWS] = '{
        48'h24_92_f1_e3_d9_85,
        48'h99_81_c1_c0_80_80,
        48'h00_10_15_12_45_30,
        48'hff_ff_ff_ff_ff_ff
    };
    // register of field 0 (sec) .. field 5 (year)
    localparam logic [7:0] FIELD_ADDR [6] = '{
        8'h02, 8'h03, 8'h04, 8'h05, 8'h07, 8'h08
    };

    logic             clk;
    logic             rst_n;
    logic             scl;
    logic             sda_oe;
    logic             sda_pull;
    logic             sda;
    rtc_time_t        time_now;
    logic             load_en;
    logic [3:0]       load_addr;
    logic [7:0]       load_data;
    int               pass_cnt;
    int               wr_cnt;
    logic [7:0][15:0] wr_log;
    logic             bus_err;
    int unsigned      cyc_cnt = 0;

    // open-drain bus is low if either side pulls
    assign sda = ~(sda_oe | sda_pull);

    always #5 clk = ~clk;

    rtc_top #(
        .TIME_INIT   (TIME_INIT),
        .WAIT_CYCLES (WAIT_CYCLES),
        .CLK_DIV     (CLK_DIV),
        .DEV_ADDR    (DEV_ADDR)
    ) rtc_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .sda_in   (sda),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .time_now (time_now)
    );

    pcf8563_model #(
        .DEV_ADDR (DEV_ADDR)
    ) pcf8563_model_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .scl       (scl),
        .sda       (sda),
        .sda_pull  (sda_pull),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .pass_cnt  (pass_cnt),
        .wr_cnt    (wr_cnt),
        .wr_log    (wr_log),
        .bus_err   (bus_err)
    );

    // valid BCD bits only
    function automatic rtc_time_t mask_time(input rtc_time_t t);
        rtc_time_t m;
        m.sec  = t.sec  & MASK_SEC;
        m.min  = t.min  & MASK_MIN;
        m.hour = t.hour & MASK_HOUR;
        m.day  = t.day  & MASK_DAY;
        m.mon  = t.mon  & MASK_MON;
        m.year = t.year & MASK_YEAR;
        return m;
    endfunction

    task automatic end_with_fail();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        end_with_fail();
    endtask

    task automatic check_val(input string name, input logic [47:0] exp_v,
                             input logic [47:0] act_v);
        assert (act_v === exp_v) else begin
            $display("CHECK FAILED at %0t: %s expected %0h, actual %0h",
                     $time, name, exp_v, act_v);
            end_with_fail();
        end
    endtask

    // one register per cycle through the model hook
    task automatic load_row(input rtc_time_t t);
        int i;
        for (i = 0; i < 6; i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = FIELD_ADDR[i][3:0];
            load_data = t[8*i +: 8];
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic wait_passes(input int n);
        int target;
        target = pass_cnt + n;
        while (pass_cnt < target) begin
            @(negedge clk);
        end
    endtask

    //******************************
    // watchdogs
    //******************************
    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        assert (cyc_cnt < TIMEOUT_CYCLES)
            else abort_run("read passes stalled, run hit its cycle limit");
    end

    always @(negedge clk) begin
        assert (!bus_err)
            else abort_run("bus model saw an illegal START, STOP or read");
    end

    //******************************
    // main sequence
    //******************************
    initial begin
        int i;
        clk       = 1'b0;
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = 4'h0;
        load_data = 8'h00;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // bus idle through the power-up wait
        repeat (WAIT_CYCLES) begin
            @(negedge clk);
            check_val("scl", 48'(1'b1), 48'(scl));
            check_val("sda_oe", 48'(1'b0), 48'(sda_oe));
        end

        // write pass in map order then start time read back
        wait_passes(2);
        check_val("write count", 48'(6), 48'(wr_cnt));
        for (i = 0; i < 6; i++) begin
            check_val($sformatf("write %0d address", i), 48'(FIELD_ADDR[i]),
                      48'(wr_log[i][15:8]));
            check_val($sformatf("write %0d data", i), 48'(TIME_INIT[8*i +: 8]),
                      48'(wr_log[i][7:0]));
        end
        check_val("time_now", mask_time(TIME_INIT), time_now);

        // new chip contents show up masked and no more writes happen
        for (i = 0; i < NUM_ROWS; i++) begin
            load_row(ROWS[i]);
            wait_passes(2);
            check_val("time_now", mask_time(ROWS[i]), time_now);
            check_val("write count", 48'(6), 48'(wr_cnt));
        end

        @(negedge clk);
        if (bus_err) begin
            abort_run("bus model flagged an error at the end of the run");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule
